// File: src/dcache_tag_pkg.sv
// Shared address, operation and request/response types for the data cache tag pipeline
`default_nettype none

package dcache_tag_pkg;

    // ##################################################################
    // Address
    // ##################################################################

    localparam int ADDR_W = 32;                 // Core byte address width

    typedef logic [ADDR_W-1:0] addr_t;          // Byte address

    // ##################################################################
    // Request and response
    // ##################################################################

    // Operation carried with each request
    typedef enum logic [1:0] {
        op_lookup    = 2'd0,                    // Probe only
        op_fill      = 2'd1,                    // Probe, allocate on miss
        op_clear_set = 2'd2                     // Invalidate every way of the set
    } dtag_op_e;

    // Request as presented at the top and carried down the pipe
    typedef struct packed {
        dtag_op_e op;
        addr_t    addr;
    } dtag_req_t;

    // Registered result of stage 2, way travels beside it one-hot
    typedef struct packed {
        logic  hit;                             // Tag matched a valid way
        logic  filled;                          // Miss allocated a new line
        addr_t addr;                            // Echo of request address
    } dtag_resp_t;

endpackage

`default_nettype wire

// File: src/tag_bank.sv
// One way's tag store, a true dual-port read-first RAM cleared to zero at start
`default_nettype none

module tag_bank #(
    parameter int WIDTH = 22,                   // Entry width, valid bit plus tag
    parameter int DEPTH = 64                    // Number of sets
) (
    input  logic                     clk,

    // Port A, stage-1 read or set clear
    input  logic                     en_a,
    input  logic                     wen_a,
    input  logic [$clog2(DEPTH)-1:0] addr_a,
    input  logic [WIDTH-1:0]         data_in_a,
    output logic [WIDTH-1:0]         data_out_a,

    // Port B, allocation update or invalidate probe
    input  logic                     en_b,
    input  logic                     wen_b,
    input  logic [$clog2(DEPTH)-1:0] addr_b,
    input  logic [WIDTH-1:0]         data_in_b,
    output logic [WIDTH-1:0]         data_out_b
);

    // All entries start invalid
    logic [WIDTH-1:0] mem [DEPTH] = '{default: '0};

    // Both ports in one block, old contents are returned on a write
    always_ff @(posedge clk) begin
        if (en_a) begin
            if (wen_a)
                mem[addr_a] <= data_in_a;
            data_out_a <= mem[addr_a];          // Read-first
        end
        if (en_b) begin
            if (wen_b)
                mem[addr_b] <= data_in_b;
            data_out_b <= mem[addr_b];
        end
    end

    // The two writers upstream must never hit the same set together
    assert property (@(posedge clk)
        !(en_a && wen_a && en_b && wen_b && (addr_a == addr_b)))
        else $error("tag_bank: both ports write set %0d in one cycle", addr_a);

endmodule

`default_nettype wire

// File: src/dtag_banks.sv
// Tag banks for all ways with stage-2 compare, allocation port and external invalidate FSM
`default_nettype none

module dtag_banks import dcache_tag_pkg::*; #(
    parameter int WAYS     = 4,
    parameter int LINES    = 64,
    parameter int OFFSET_W = 5
) (
    input  logic            clk,
    input  logic            rst,

    input  addr_t           stage1_addr,        // Set read or cleared this cycle
    input  addr_t           stage2_addr,        // Address compared and allocated
    input  addr_t           inv_addr,           // Line to invalidate

    input  logic [WAYS-1:0] update_way,         // Victim for allocation
    input  logic            update,

    input  logic            stage1_adv,
    input  logic            stage1_inv,

    input  logic            extern_inv,         // Held until completion
    output logic            extern_inv_complete,

    output logic            tag_hit,
    output logic [WAYS-1:0] tag_hit_way
);

    localparam int LINE_W = $clog2(LINES);
    localparam int TAG_W  = ADDR_W - LINE_W - OFFSET_W;

    typedef logic [LINE_W-1:0] line_t;
    typedef logic [TAG_W:0]    dtag_entry_t;    // {valid, tag}

    // Invalidate sequencing on port B
    typedef enum logic [1:0] {
        inv_idle,                               // Waiting for a free port B
        inv_probe,                              // Tags of the line on port B output
        inv_report,                             // Completion pulse
        inv_hold                                // Wait for the request to drop
    } inv_state_e;

    dtag_entry_t      tag_line [WAYS];          // Port A read data
    dtag_entry_t      inv_tag_line [WAYS];      // Port B read data
    dtag_entry_t      stage2_entry;
    dtag_entry_t      new_entry;
    line_t            stage1_line;
    line_t            stage2_line;
    line_t            inv_line;
    line_t            port_b_line;
    logic [TAG_W-1:0] inv_tag;
    logic [WAYS-1:0]  inv_hit_way;
    logic [WAYS-1:0]  port_b_wen;
    logic             port_b_en;
    logic             inv_write;
    logic             port_clash;
    inv_state_e       inv_state;
    inv_state_e       inv_state_next;

    // ##################################################################
    // Address fields
    // ##################################################################

    assign stage1_line = stage1_addr[OFFSET_W +: LINE_W];
    assign stage2_line = stage2_addr[OFFSET_W +: LINE_W];
    assign inv_line    = inv_addr[OFFSET_W +: LINE_W];
    assign inv_tag     = inv_addr[ADDR_W-1 -: TAG_W];

    assign stage2_entry = {1'b1, stage2_addr[ADDR_W-1 -: TAG_W]};
    assign new_entry    = {update, stage2_addr[ADDR_W-1 -: TAG_W]};  // Invalid when probing

    // ##################################################################
    // Port B arbitration, update first
    // ##################################################################

    assign port_b_en   = update | extern_inv;
    assign port_b_line = update ? stage2_line : inv_line;
    assign inv_write   = (inv_state == inv_probe) & extern_inv & ~update;

    // A set clear on port A is younger than any port B write, so it wins
    assign port_clash = stage1_inv & (stage1_line == port_b_line);

    always_comb begin
        inv_state_next = inv_state;
        unique case (inv_state)
            inv_idle: begin
                if (extern_inv && !update)
                    inv_state_next = inv_probe; // Probe read issued this edge
            end
            inv_probe:  inv_state_next = inv_write ? inv_report : inv_idle;  // Retry if lost
            inv_report: inv_state_next = inv_hold;
            inv_hold: begin
                if (!extern_inv)
                    inv_state_next = inv_idle;
            end
            default:    inv_state_next = inv_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst)
            inv_state <= inv_idle;
        else
            inv_state <= inv_state_next;
    end

    assign extern_inv_complete = (inv_state == inv_report);

    // ##################################################################
    // Per-way banks and compare
    // ##################################################################

    for (genvar w = 0; w < WAYS; w++) begin : g_way
        assign inv_hit_way[w] = (inv_tag_line[w] == {1'b1, inv_tag});
        assign port_b_wen[w]  = ((update & update_way[w]) | (inv_write & inv_hit_way[w]))
                              & ~port_clash;

        tag_bank #(
            .WIDTH (TAG_W + 1),
            .DEPTH (LINES)
        ) bank (
            .clk        (clk),
            .en_a       (stage1_adv),
            .wen_a      (stage1_inv),           // Clear writes zeros
            .addr_a     (stage1_line),
            .data_in_a  ('0),
            .data_out_a (tag_line[w]),
            .en_b       (port_b_en),
            .wen_b      (port_b_wen[w]),
            .addr_b     (port_b_line),
            .data_in_b  (new_entry),
            .data_out_b (inv_tag_line[w])
        );

        assign tag_hit_way[w] = (tag_line[w] == stage2_entry);
    end

    assign tag_hit = |tag_hit_way;

endmodule

`default_nettype wire

// File: src/dtag_issue_stage.sv
// Stage 1 of the tag pipeline, registers requests and drives the bank read and set clear
`default_nettype none

module dtag_issue_stage import dcache_tag_pkg::*; #(
    parameter int OFFSET_W = 5
) (
    input  logic      clk,
    input  logic      rst,

    input  logic      req_valid,                // One-cycle strobe
    input  dtag_req_t req,

    // Port A controls for the banks
    output addr_t     stage1_addr,
    output logic      stage1_adv,
    output logic      stage1_inv,

    // Stage-2 record
    output logic      s2_valid,
    output dtag_req_t s2_req
);

    dtag_req_t s1_req;
    logic      s1_valid;

    // Valid bits step down the pipe every cycle, no stall
    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= req_valid;
            s2_valid <= s1_valid;
        end
    end

    // Payload only loads with a live request
    always_ff @(posedge clk) begin
        if (req_valid)
            s1_req <= req;
        if (s1_valid)
            s2_req <= s1_req;                   // Full address kept for the response
    end

    // ##################################################################
    // Bank port A
    // ##################################################################

    assign stage1_adv  = s1_valid;              // Read on every request
    assign stage1_inv  = s1_valid & (s1_req.op == op_clear_set);
    assign stage1_addr = {s1_req.addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};  // Line aligned

endmodule

`default_nettype wire

// File: src/victim_select.sv
// Round-robin victim pointer for allocation, one-hot over the ways
`default_nettype none

module victim_select #(
    parameter int WAYS = 4
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            allocate,           // Pulse per line allocated
    output logic [WAYS-1:0] victim_way
);

    logic [WAYS-1:0] ptr_next;

    // Rotate left, top way wraps to way 0
    assign ptr_next = (victim_way << 1) | (victim_way >> (WAYS - 1));

    always_ff @(posedge clk) begin
        if (rst)
            victim_way <= WAYS'(1);             // Start at way 0
        else if (allocate)
            victim_way <= ptr_next;
    end

    // Exactly one candidate way at all times
    assert property (@(posedge clk) disable iff (rst) $onehot(victim_way))
        else $error("victim_select: pointer not one-hot %b", victim_way);

endmodule

`default_nettype wire

// File: src/dtag_check_stage.sv
// Stage 2 of the tag pipeline, resolves hit with fill forwarding, allocates and registers result
`default_nettype none

module dtag_check_stage import dcache_tag_pkg::*; #(
    parameter int WAYS     = 4,
    parameter int LINES    = 64,
    parameter int OFFSET_W = 5
) (
    input  logic            clk,
    input  logic            rst,

    input  logic            s2_valid,
    input  dtag_req_t       s2_req,
    input  logic [WAYS-1:0] tag_hit_way,        // Raw bank compare
    input  logic [WAYS-1:0] victim_way,

    output logic            update,             // Allocation write this cycle
    output logic [WAYS-1:0] update_way,
    output logic            allocate,           // Advance victim pointer

    output logic            resp_valid,
    output dtag_resp_t      resp,
    output logic [WAYS-1:0] resp_way
);

    localparam int LINE_W = $clog2(LINES);
    localparam int TAG_W  = ADDR_W - LINE_W - OFFSET_W;

    typedef logic [LINE_W-1:0] line_t;
    typedef logic [TAG_W-1:0]  tag_t;

    line_t           s2_line;
    tag_t            s2_tag;
    line_t           fill_line;                 // Previous cycle's fill
    tag_t            fill_tag;
    logic [WAYS-1:0] fill_way;
    logic            fill_valid;
    logic            same_set;
    logic            same_line;
    logic            is_fill;
    logic            is_clear;
    logic            hit;
    logic [WAYS-1:0] bank_way;
    logic [WAYS-1:0] hit_way;

    assign s2_line  = s2_req.addr[OFFSET_W +: LINE_W];
    assign s2_tag   = s2_req.addr[ADDR_W-1 -: TAG_W];
    assign is_fill  = (s2_req.op == op_fill);
    assign is_clear = (s2_req.op == op_clear_set);

    // ##################################################################
    // Hit resolution
    // ##################################################################

    // Banks were read before the last fill landed, patch that way
    assign same_set  = fill_valid & (fill_line == s2_line);
    assign same_line = same_set & (fill_tag == s2_tag);
    assign bank_way  = same_set ? (tag_hit_way & ~fill_way) : tag_hit_way;  // Evicted line
    assign hit_way   = is_clear ? '0 : (same_line ? fill_way : bank_way);
    assign hit       = |hit_way;

    assign update     = s2_valid & is_fill & ~hit;
    assign update_way = victim_way;
    assign allocate   = update;

    // Forwarding record
    always_ff @(posedge clk) begin
        if (rst)
            fill_valid <= 1'b0;
        else
            fill_valid <= update;
    end

    always_ff @(posedge clk) begin
        if (update) begin
            fill_line <= s2_line;
            fill_tag  <= s2_tag;
            fill_way  <= victim_way;
        end
    end

    // ##################################################################
    // Response
    // ##################################################################

    always_ff @(posedge clk) begin
        if (rst)
            resp_valid <= 1'b0;
        else
            resp_valid <= s2_valid;
    end

    always_ff @(posedge clk) begin
        resp.hit    <= hit;
        resp.filled <= update;
        resp.addr   <= s2_req.addr;
        resp_way    <= update ? victim_way : hit_way;  // Zero on plain miss
    end

    // Bank contents plus forwarding must never name two ways for one tag
    assert property (@(posedge clk) disable iff (rst) s2_valid |-> $onehot0(hit_way))
        else $error("dtag_check_stage: multiple ways hit %b", hit_way);

endmodule

`default_nettype wire

// File: src/dcache_tag_top.sv
// Top of the data cache tag pipeline, connects both stages, the tag banks and the victim pointer
`default_nettype none

module dcache_tag_top import dcache_tag_pkg::*; #(
    parameter int WAYS     = 4,                 // Associativity
    parameter int LINES    = 64,                // Sets per way
    parameter int OFFSET_W = 5                  // Byte offset bits of a line
) (
    input  logic            clk,
    input  logic            rst,

    // Request, one-cycle strobe
    input  logic            req_valid,
    input  dtag_req_t       req,

    // External invalidate, level held until done
    input  logic            inv_req,
    input  addr_t           inv_addr,

    output logic            resp_valid,
    output dtag_resp_t      resp,
    output logic [WAYS-1:0] resp_way,
    output logic            inv_done
);

    addr_t           stage1_addr;
    logic            stage1_adv;
    logic            stage1_inv;
    logic            s2_valid;
    dtag_req_t       s2_req;
    logic [WAYS-1:0] tag_hit_way;
    logic            update;
    logic [WAYS-1:0] update_way;
    logic            allocate;
    logic [WAYS-1:0] victim_way;

    // ##################################################################
    // Pipeline
    // ##################################################################

    dtag_issue_stage #(.OFFSET_W(OFFSET_W)) issue (
        .clk, .rst, .req_valid, .req,
        .stage1_addr, .stage1_adv, .stage1_inv,
        .s2_valid, .s2_req
    );

    dtag_banks #(.WAYS(WAYS), .LINES(LINES), .OFFSET_W(OFFSET_W)) banks (
        .clk, .rst,
        .stage1_addr,
        .stage2_addr         (s2_req.addr),     // Compare and allocate address
        .inv_addr,
        .update_way, .update,
        .stage1_adv, .stage1_inv,
        .extern_inv          (inv_req),
        .extern_inv_complete (inv_done),
        .tag_hit             (),                // Check stage works per way
        .tag_hit_way
    );

    dtag_check_stage #(.WAYS(WAYS), .LINES(LINES), .OFFSET_W(OFFSET_W)) check (
        .clk, .rst, .s2_valid, .s2_req, .tag_hit_way, .victim_way,
        .update, .update_way, .allocate,
        .resp_valid, .resp, .resp_way
    );

    victim_select #(.WAYS(WAYS)) victim (
        .clk, .rst, .allocate, .victim_way
    );

endmodule

`default_nettype wire

// File: tb/tb_clock.sv
// Clock and reset source for the testbench, 20 ns period with reset held for the first 10 cycles
`default_nettype none

module tb_clock (
    output logic clk,
    output logic rst
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int HALF_PERIOD  = 10;           // 20 ns period
    localparam int RESET_CYCLES = 10;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // Release on a falling edge, clear of the sampling edge
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

`default_nettype wire

// File: tb/tb_checker.sv
// Reference model of the tag pipeline, compares every response and invalidate pulse against it
`default_nettype none

module tb_checker import dcache_tag_pkg::*; #(
    parameter int WAYS     = 4,
    parameter int LINES    = 64,
    parameter int OFFSET_W = 5
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            req_valid,
    input  dtag_req_t       req,
    input  logic            inv_req,
    input  addr_t           inv_addr,
    input  logic            inv_done,
    input  logic            resp_valid,
    input  dtag_resp_t      resp,
    input  logic [WAYS-1:0] resp_way,
    output int              mismatch_count,
    output int              protocol_count,
    output int              pending             // Responses still owed
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int LINE_W = $clog2(LINES);
    localparam int TAG_W  = ADDR_W - LINE_W - OFFSET_W;

    // Expected response and the cycle it is due
    typedef struct packed {
        logic            hit;
        logic            filled;
        addr_t           addr;
        logic [WAYS-1:0] way;
        int unsigned     due;
    } expect_t;

    logic             model_valid [LINES][WAYS];
    logic [TAG_W-1:0] model_tag   [LINES][WAYS];
    int unsigned      model_ptr;                // Round-robin victim
    int unsigned      cycle;
    logic             inv_open;                 // Invalidate seen, no pulse yet
    expect_t          exp_q [$];

    function automatic int unsigned set_of(input addr_t a);
        return 32'(a[OFFSET_W +: LINE_W]);
    endfunction

    function automatic logic [TAG_W-1:0] tag_of(input addr_t a);
        return a[ADDR_W-1 -: TAG_W];
    endfunction

    // ####################################################################
    // Reference model
    // ####################################################################

    // Result of a request against the model as it stands
    function automatic expect_t predict(input dtag_req_t r);
        expect_t     e;
        int unsigned s;
        e      = '0;
        s      = set_of(r.addr);
        e.addr = r.addr;
        if (r.op != op_clear_set) begin
            for (int w = 0; w < WAYS; w++) begin
                if (model_valid[s][w] && model_tag[s][w] == tag_of(r.addr)) begin
                    e.hit = 1'b1;
                    e.way = WAYS'(1) << w;
                end
            end
            if (r.op == op_fill && !e.hit) begin    // Allocate into pointer way
                e.filled = 1'b1;
                e.way    = WAYS'(1) << model_ptr;
            end
        end
        return e;
    endfunction

    task automatic apply_request(input dtag_req_t r, input expect_t e);
        int unsigned s;
        s = set_of(r.addr);
        if (r.op == op_clear_set) begin
            for (int w = 0; w < WAYS; w++)
                model_valid[s][w] = 1'b0;
        end else if (e.filled) begin
            model_valid[s][model_ptr] = 1'b1;
            model_tag[s][model_ptr]   = tag_of(r.addr);
            model_ptr                 = (model_ptr + 1) % WAYS;
        end
    endtask

    // Drops only the way holding this exact tag
    task automatic invalidate_entry(input addr_t a);
        int unsigned s;
        s = set_of(a);
        for (int w = 0; w < WAYS; w++) begin
            if (model_valid[s][w] && model_tag[s][w] == tag_of(a))
                model_valid[s][w] = 1'b0;
        end
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] want);
        if (got !== want) begin
            mismatch_count++;
            $display("Fail %s: got %h expected %h at cycle %0d", name, got, want, cycle);
        end
    endtask

    // ####################################################################
    // Monitor, sampled on the rising edge
    // ####################################################################

    always @(posedge clk) begin : monitor
        expect_t e;
        if (rst) begin
            mismatch_count = 0;
            protocol_count = 0;
            pending        = 0;
            cycle          = 0;
            model_ptr      = 0;                 // Way 0 first
            inv_open       = 1'b0;
            exp_q.delete();
            for (int s = 0; s < LINES; s++)
                for (int w = 0; w < WAYS; w++)
                    model_valid[s][w] = 1'b0;   // RAMs start at zero
        end else begin
            cycle++;
            // Invalidation lands before any request sampled on this edge
            if (inv_done) begin
                if (!inv_open) begin
                    protocol_count++;
                    $display("inv_done pulsed with no invalidation pending at cycle %0d", cycle);
                end else begin
                    invalidate_entry(inv_addr);
                end
                inv_open = 1'b0;
            end
            if (inv_req && !inv_done)
                inv_open = 1'b1;

            if (resp_valid) begin
                if (exp_q.size() == 0) begin
                    protocol_count++;
                    $display("Response with no request outstanding at cycle %0d", cycle);
                end else begin
                    e = exp_q.pop_front();
                    if (e.due != cycle) begin
                        protocol_count++;
                        $display("Response came at cycle %0d but was due at cycle %0d",
                                 cycle, e.due);
                    end
                    check_value("resp.hit", 64'(resp.hit), 64'(e.hit));
                    check_value("resp.filled", 64'(resp.filled), 64'(e.filled));
                    check_value("resp.addr", 64'(resp.addr), 64'(e.addr));
                    check_value("resp_way", 64'(resp_way), 64'(e.way));
                end
            end else if (exp_q.size() != 0 && exp_q[0].due <= cycle) begin
                protocol_count++;
                $display("No response for the request to address %h", exp_q[0].addr);
                void'(exp_q.pop_front());
            end

            if (req_valid) begin
                e     = predict(req);
                e.due = cycle + 3;              // Response visible two edges later
                apply_request(req, e);
                exp_q.push_back(e);
            end
            pending = exp_q.size();
        end
    end

endmodule

`default_nettype wire

// File: tb/tb_top.sv
// Testbench top, drives requests and invalidations into the tag pipeline and prints the verdict
`default_nettype none

module tb_top import dcache_tag_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int WAYS          = 4;
    localparam int LINES         = 64;
    localparam int OFFSET_W      = 5;
    localparam int LINE_W        = $clog2(LINES);
    localparam int TAG_W         = ADDR_W - LINE_W - OFFSET_W;
    localparam int INV_TIMEOUT   = 200;         // Cycles allowed per invalidation
    localparam int DRAIN_TIMEOUT = 50;
    localparam int RANDOM_REQS   = 400;

    logic            clk;
    logic            rst;
    logic            req_valid;
    dtag_req_t       req;
    logic            inv_req;
    addr_t           inv_addr;
    logic            resp_valid;
    dtag_resp_t      resp;
    logic [WAYS-1:0] resp_way;
    logic            inv_done;
    int              mismatch_count;
    int              protocol_count;
    int              pending;
    int              timeout_count;
    logic [31:0]     lfsr_state;

    tb_clock clock0 (.clk, .rst);

    dcache_tag_top #(.WAYS(WAYS), .LINES(LINES), .OFFSET_W(OFFSET_W)) dut0 (
        .clk, .rst, .req_valid, .req, .inv_req, .inv_addr,
        .resp_valid, .resp, .resp_way, .inv_done
    );

    tb_checker #(.WAYS(WAYS), .LINES(LINES), .OFFSET_W(OFFSET_W)) chk0 (
        .clk, .rst, .req_valid, .req, .inv_req, .inv_addr, .inv_done,
        .resp_valid, .resp, .resp_way, .mismatch_count, .protocol_count, .pending
    );

    // ####################################################################
    // Stimulus helpers
    // ####################################################################

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);   // One step per bit
            v          = {v[30:0], lfsr_state[0]};
        end
    endtask

    // Small tag pool above a fixed base
    function automatic addr_t make_addr(input int t, input int s, input int off);
        return {TAG_W'(32'h1A50 + t), LINE_W'(s), OFFSET_W'(off)};
    endfunction

    task automatic drive_req(input dtag_op_e op, input addr_t a);
        req_valid = 1'b1;
        req.op    = op;
        req.addr  = a;
    endtask

    task automatic send(input dtag_op_e op, input addr_t a);
        @(negedge clk);
        drive_req(op, a);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            req_valid = 1'b0;
        end
    endtask

    // Sets 0 to 3 only, tags 0 to 7
    task automatic random_request(input bit fill_only);
        logic [31:0] op_bits;
        logic [31:0] tag_bits;
        logic [31:0] set_bits;
        logic [31:0] off_bits;
        dtag_op_e    op;
        draw_bits(3, op_bits);
        draw_bits(3, tag_bits);
        draw_bits(2, set_bits);
        draw_bits(5, off_bits);
        if (fill_only || (op_bits >= 3 && op_bits <= 6))
            op = op_fill;
        else if (op_bits == 7)
            op = op_clear_set;                  // Rare, keeps hits common
        else
            op = op_lookup;
        drive_req(op, make_addr(int'(tag_bits), int'(set_bits), int'(off_bits)));
    endtask

    // Hold inv_req until the done pulse, optional fills to other sets meanwhile
    task automatic invalidate(input addr_t a, input bit busy);
        logic [31:0] gap;
        int          waited;
        bit          done;
        idle_cycles(3);                         // Pipe empty before the probe
        inv_req  = 1'b1;
        inv_addr = a;
        done     = 1'b0;
        waited   = 0;
        while (!done && waited < INV_TIMEOUT) begin
            @(negedge clk);
            waited++;
            req_valid = 1'b0;
            if (inv_done) begin
                done = 1'b1;
            end else if (busy) begin
                draw_bits(1, gap);
                if (gap[0])
                    random_request(1'b1);
            end
        end
        inv_req = 1'b0;
        if (!done) begin
            timeout_count++;
            $display("Timeout: no inv_done within %0d cycles for address %h", INV_TIMEOUT, a);
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        idle_cycles(1);
        while (pending != 0 && waited < DRAIN_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (pending != 0) begin
            timeout_count++;
            $display("Timeout: %0d responses still outstanding", pending);
        end
    endtask

    // ####################################################################
    // Test sequence
    // ####################################################################

    initial begin : stimulus
        int          waited;
        logic [31:0] gap;
        req_valid     = 1'b0;
        req           = '0;
        inv_req       = 1'b0;
        inv_addr      = '0;
        timeout_count = 0;
        lfsr_state    = 32'd99983;

        waited = 0;
        while (rst !== 1'b0 && waited < 100) begin
            @(negedge clk);
            waited++;
        end
        if (rst !== 1'b0) begin
            timeout_count++;
            $display("Timeout: reset never released");
        end

        idle_cycles(5);                         // Quiet, no responses expected
        for (int s = 0; s < 4; s++)
            send(op_lookup, make_addr(s, s, 0));    // Cold misses
        idle_cycles(3);

        send(op_fill, make_addr(1, 1, 4));      // Fill then hit
        idle_cycles(3);
        send(op_lookup, make_addr(1, 1, 8));
        idle_cycles(3);

        for (int t = 0; t <= WAYS; t++) begin   // One more tag than ways
            send(op_fill, make_addr(t, 2, t));
            idle_cycles(2);
        end
        send(op_lookup, make_addr(0, 2, 0));    // Oldest gone
        send(op_lookup, make_addr(WAYS, 2, 0));
        idle_cycles(3);

        send(op_fill, make_addr(2, 3, 0));      // Back to back into set 3
        send(op_lookup, make_addr(2, 3, 1));
        send(op_fill, make_addr(3, 3, 0));
        send(op_fill, make_addr(4, 3, 0));
        send(op_fill, make_addr(4, 3, 2));
        send(op_lookup, make_addr(2, 3, 0));
        idle_cycles(3);

        send(op_fill, make_addr(6, 2, 0));      // Fill racing a set clear
        send(op_clear_set, make_addr(0, 2, 0));
        for (int t = 0; t <= WAYS + 2; t++)
            send(op_lookup, make_addr(t, 2, 0));
        idle_cycles(3);

        send(op_fill, make_addr(5, 8, 0));
        send(op_fill, make_addr(6, 8, 0));
        invalidate(make_addr(5, 8, 0), 1'b0);
        send(op_lookup, make_addr(5, 8, 0));
        send(op_lookup, make_addr(6, 8, 0));
        send(op_fill, make_addr(5, 8, 0));
        invalidate(make_addr(6, 8, 0), 1'b1);   // Fills in sets 0 to 3 meanwhile
        send(op_lookup, make_addr(5, 8, 0));
        send(op_lookup, make_addr(6, 8, 0));
        invalidate(make_addr(7, 9, 0), 1'b1);   // Line not present
        idle_cycles(3);

        for (int i = 0; i < RANDOM_REQS; i++) begin
            draw_bits(2, gap);
            @(negedge clk);
            if (gap == 0)
                req_valid = 1'b0;
            else
                random_request(1'b0);
        end
        drain();
        idle_cycles(4);                         // Catch stray responses

        $display("Errors: mismatches %0d, protocol %0d, timeouts %0d",
                 mismatch_count, protocol_count, timeout_count);
        if (mismatch_count == 0 && protocol_count == 0 && timeout_count == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
src/dcache_tag_pkg.sv
src/tag_bank.sv
src/dtag_banks.sv
src/dtag_issue_stage.sv
src/victim_select.sv
src/dtag_check_stage.sv
src/dcache_tag_top.sv
tb/tb_clock.sv
tb/tb_checker.sv
tb/tb_top.sv

// File: Makefile
# Verilator lint, simulation and clean for the data cache tag pipeline

VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/1ps
VFLAGS    ?=
PASS_MSG  ?= RESULT: PASS

COMMON = --timing --timescale $(TIMESCALE) -f $(FILELIST) --top-module $(TOP) $(VFLAGS)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(COMMON)

build:
	$(VERILATOR) --binary $(COMMON) --Mdir $(BUILD_DIR)

# The run passes only if the pass line shows up in the simulator output
sim: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
